/* acia.sv */
// 6850-style acia, 8N1 only
// control and status registers, receive buffer, irq and serial engines
`timescale 1ns/1ns
`default_nettype none

module acia import acia_loop_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       cs,
    input  logic       we,
    input  logic       rs,
    input  logic [7:0] din,
    output logic [7:0] dout,
    input  logic       rx,
    output logic       tx,
    output logic       irq
);

    logic [7:0] ctrl;
    logic       mr_hold;
    logic       core_rst_n;
    clk_div_e   div_sel;
    logic       tick;
    logic [6:0] bit_len;
    logic       wr_ctrl;
    logic       wr_data;
    logic       rd_data;
    logic       tx_empty;
    logic [7:0] rx_word;
    logic       rx_done;
    logic       rx_ferr;
    logic [7:0] rdr;
    logic       rdrf;
    logic       fe;
    logic [7:0] status;

    assign wr_ctrl = cs && we && !rs;
    assign wr_data = cs && we && rs;
    assign rd_data = cs && !we && rs;
    assign div_sel = clk_div_e'(ctrl[1:0]);
    // serial engines are held cleared while master reset is selected
    assign core_rst_n = arst_n && !mr_hold;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            ctrl    <= ctrl_master;   // comes up in master reset
            mr_hold <= 1'b1;
        end else if (wr_ctrl) begin
            ctrl    <= din;
            mr_hold <= (din[1:0] == master_reset);
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdrf <= 1'b0;
            fe   <= 1'b0;
        end else if (wr_ctrl && din[1:0] == master_reset) begin
            rdrf <= 1'b0;
            fe   <= 1'b0;
        end else if (rx_done) begin
            rdrf <= 1'b1;     // a new byte overwrites an unread one
            fe   <= rx_ferr;
        end else if (rd_data) begin
            rdrf <= 1'b0;
            fe   <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (rx_done) begin
            rdr <= rx_word;
        end
    end

    assign irq = (rdrf && ctrl[ctrl_rie]) || (tx_empty && ctrl[6:5] == tc_tie);

    always_comb begin
        status          = 8'h00;
        status[st_rdrf] = rdrf;
        status[st_tdre] = tx_empty;
        status[st_fe]   = fe;
        status[st_irq]  = irq;
    end

    assign dout = rs ? rdr : status;

    acia_baud i_baud (
        .clk     (clk),
        .arst_n  (arst_n),
        .div_sel (div_sel),
        .tick    (tick),
        .bit_len (bit_len)
    );

    acia_tx i_tx (
        .clk     (clk),
        .arst_n  (core_rst_n),
        .tick    (tick),
        .bit_len (bit_len),
        .load    (wr_data),
        .data    (din),
        .empty   (tx_empty),
        .tx      (tx)
    );

    acia_rx i_rx (
        .clk       (clk),
        .arst_n    (core_rst_n),
        .tick      (tick),
        .bit_len   (bit_len),
        .rx        (rx),
        .data      (rx_word),
        .done      (rx_done),
        .frame_err (rx_ferr)
    );

endmodule

`default_nettype wire

/* acia_baud.sv */
// acia oversample tick generator
// one tick every ovs_div clocks, ticks per bit from the divide select
`timescale 1ns/1ns
`default_nettype none

module acia_baud import acia_loop_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  clk_div_e   div_sel,
    output logic       tick,
    output logic [6:0] bit_len
);

    logic [ovs_cnt_w-1:0] div_cnt;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else if (div_sel == master_reset) begin
            div_cnt <= '0;   // frozen while in master reset
            tick    <= 1'b0;
        end else if (div_cnt == ovs_cnt_w'(ovs_div - 1)) begin
            div_cnt <= '0;
            tick    <= 1'b1;
        end else begin
            div_cnt <= div_cnt + 1'b1;
            tick    <= 1'b0;
        end
    end

    assign bit_len = (div_sel == div_64) ? 7'(bit_ticks_64) : 7'(bit_ticks_16);

endmodule

`default_nettype wire

/* acia_loop.f */
acia_loop_pkg.sv
acia_baud.sv
acia_tx.sv
acia_rx.sv
acia.sv
acia_pump.sv
acia_loop_top.sv
acia_loop_asserts.sv
tb_acia_loop.sv

/* acia_loop_asserts.sv */
// acia_loop bus checks
// concurrent assertions bound into the memory pump
`timescale 1ns/1ns
`default_nettype none

module acia_loop_asserts import acia_loop_pkg::*; (
    input logic              clk,
    input logic              arst_n,
    input pump_state_e       state,
    input logic              cs,
    input logic              we,
    input logic              rs,
    input logic              mem_we,
    input logic [addr_w-1:0] mem_addr
);

    int fail_count = 0;   // read back by the testbench at the end

    // a store always follows the receive data read on the acia bus
    store_after_data_read: assert property (@(posedge clk) disable iff (!arst_n)
        mem_we |-> (state == st_rx_store) && $past(cs && !we && rs))
        else begin
            $error("mem_we high without a receive data read before it");
            fail_count++;
        end

    bus_idle_during_store: assert property (@(posedge clk) disable iff (!arst_n)
        !(cs && mem_we))
        else begin
            $error("acia select and memory write high together");
            fail_count++;
        end

    // control register is only written during configuration
    no_ctrl_write_late: assert property (@(posedge clk) disable iff (!arst_n)
        (state != st_reset_acia && state != st_config) |-> !(cs && we && !rs))
        else begin
            $error("control register write after configuration");
            fail_count++;
        end

    store_in_rx_region: assert property (@(posedge clk) disable iff (!arst_n)
        mem_we |-> (mem_addr >= rx_base) && (mem_addr < rx_base + addr_w'(rx_len)))
        else begin
            $error("store address %h outside the receive region", mem_addr);
            fail_count++;
        end

endmodule

`default_nettype wire

/* acia_loop_pkg.sv */
// acia_loop shared definitions
// baud divider, memory map, register fields and FSM encodings
`default_nettype none

package acia_loop_pkg;

    localparam int ovs_div      = 2;               // clocks per oversample tick
    localparam int ovs_cnt_w    = $clog2(ovs_div);
    localparam int bit_ticks_16 = 16;
    localparam int bit_ticks_64 = 64;

    localparam int              addr_w   = 16;
    localparam logic [addr_w-1:0] tx_base = 16'h0000; // zero-terminated string
    localparam logic [addr_w-1:0] rx_base = 16'h0100; // receive ring
    localparam int              rx_len   = 16;
    localparam int              rx_idx_w = $clog2(rx_len);

    // control register: rie, tx ctrl 00, 8N1 word select, /16
    localparam logic [7:0] ctrl_init   = 8'h95;
    localparam logic [7:0] ctrl_master = 8'h03;  // counter divide 11
    localparam int         ctrl_rie    = 7;
    localparam logic [1:0] tc_tie      = 2'b01;  // tx ctrl field with tx irq on

    // status bit positions
    localparam int st_rdrf = 0;
    localparam int st_tdre = 1;
    localparam int st_fe   = 4;
    localparam int st_irq  = 7;

    typedef enum logic [1:0] {
        div_16a      = 2'b00,  // /1 not supported, runs as /16
        div_16       = 2'b01,
        div_64       = 2'b10,
        master_reset = 2'b11
    } clk_div_e;

    typedef enum logic [3:0] {
        st_reset_acia,
        st_config,
        st_idle,
        st_tx_fetch,
        st_tx_write,
        st_rx_status,
        st_rx_data,
        st_rx_store,
        st_done
    } pump_state_e;

    typedef enum logic [1:0] {tx_idle, tx_start, tx_data, tx_stop} tx_state_e;
    typedef enum logic [1:0] {rx_idle, rx_start, rx_data, rx_stop} rx_state_e;

endpackage

`default_nettype wire

/* acia_loop_top.sv */
// acia_loop top level
// memory pump driving the acia, memory and serial pins brought out
`timescale 1ns/1ns
`default_nettype none

module acia_loop_top import acia_loop_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              rx,
    output logic              tx,
    output logic [addr_w-1:0] mem_addr,
    input  logic [7:0]        mem_rdata,
    output logic [7:0]        mem_wdata,
    output logic              mem_we
);

    logic       acia_cs;
    logic       acia_we;
    logic       acia_rs;
    logic       acia_irq;
    logic [7:0] acia_din;
    logic [7:0] acia_dout;

    acia_pump i_pump (
        .clk       (clk),
        .arst_n    (arst_n),
        .irq       (acia_irq),
        .acia_dout (acia_dout),
        .cs        (acia_cs),
        .we        (acia_we),
        .rs        (acia_rs),
        .acia_din  (acia_din),
        .mem_addr  (mem_addr),
        .mem_rdata (mem_rdata),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we)
    );

    acia i_acia (
        .clk    (clk),
        .arst_n (arst_n),
        .cs     (acia_cs),
        .we     (acia_we),
        .rs     (acia_rs),
        .din    (acia_din),
        .dout   (acia_dout),
        .rx     (rx),
        .tx     (tx),
        .irq    (acia_irq)
    );

endmodule

`default_nettype wire

/* acia_loop_vectors.txt */
// @00 transmit string, one byte per word, 000 ends it
// @10 receive entries {bad_stop, byte}, fff ends them; @30 expected receive region
@00
// "acia loop!"
061 063 069 061 020 06c 06f 06f 070 021
000
@10
// entries 2 and 8 carry a low stop bit
031 0c2 17e 05a 0ff 000 081 03c 1a5 0e7
012 0b4 069 0d8 047 09e 023 0f0 08d 056
fff
@30
// last two good bytes wrap into slots 0 and 1
08d 056 05a 0ff 000 081 03c 0e7
012 0b4 069 0d8 047 09e 023 0f0

/* acia_pump.sv */
// memory pump for the acia
// streams a zero-terminated string out, stores received bytes in a ring
`timescale 1ns/1ns
`default_nettype none

module acia_pump import acia_loop_pkg::*; (
    input  logic              clk,
    input  logic              arst_n,
    input  logic              irq,
    input  logic [7:0]        acia_dout,
    output logic              cs,
    output logic              we,
    output logic              rs,
    output logic [7:0]        acia_din,
    output logic [addr_w-1:0] mem_addr,
    input  logic [7:0]        mem_rdata,
    output logic [7:0]        mem_wdata,
    output logic              mem_we
);

    pump_state_e         state;
    pump_state_e         state_d;
    logic [addr_w-1:0]   tx_ptr;
    logic [rx_idx_w-1:0] rx_idx;
    logic                tx_end;
    logic                rx_fe;
    logic [7:0]          rx_byte;

    always_comb begin
        state_d = state;
        case (state)
            st_reset_acia: if (cs && we) state_d = st_config;   // mr write on bus
            st_config:     state_d = st_idle;
            st_idle: begin
                if (irq) begin
                    state_d = st_rx_status;   // receive goes first
                end else if (acia_dout[st_tdre]) begin
                    state_d = st_tx_fetch;
                end
            end
            st_tx_fetch:  state_d = (mem_rdata == 8'h00) ? st_done : st_tx_write;
            st_tx_write:  state_d = st_idle;
            st_rx_status: state_d = st_rx_data;
            st_rx_data:   state_d = st_rx_store;
            st_rx_store:  state_d = tx_end ? st_done : st_idle;
            st_done:      if (irq) state_d = st_rx_status;
            default:      state_d = st_idle;
        endcase
    end

    // bus strobes are registered from the next state
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state  <= st_reset_acia;
            cs     <= 1'b0;
            we     <= 1'b0;
            rs     <= 1'b0;
            tx_ptr <= '0;
            rx_idx <= '0;
            tx_end <= 1'b0;
            rx_fe  <= 1'b0;
        end else begin
            state <= state_d;
            cs    <= state_d inside {st_reset_acia, st_config, st_idle,
                                     st_tx_write, st_rx_status, st_rx_data};
            we    <= state_d inside {st_reset_acia, st_config, st_tx_write};
            rs    <= state_d inside {st_tx_write, st_rx_data};
            if (state == st_tx_write) begin
                tx_ptr <= tx_ptr + 1'b1;
            end
            if (state == st_tx_fetch && state_d == st_done) begin
                tx_end <= 1'b1;   // terminator seen
            end
            if (state == st_rx_status) begin
                rx_fe <= acia_dout[st_fe];
            end
            if (state == st_rx_store && !rx_fe) begin
                rx_idx <= (rx_idx == rx_idx_w'(rx_len - 1)) ? '0 : rx_idx + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        case (state_d)
            st_reset_acia: acia_din <= ctrl_master;
            st_config:     acia_din <= ctrl_init;
            st_tx_write:   acia_din <= mem_rdata;
            default:       acia_din <= acia_din;
        endcase
        if (state == st_rx_data) begin
            rx_byte <= acia_dout;
        end
    end

    // string address sits on the bus outside of stores, so rdata is ready
    assign mem_addr  = (state == st_rx_store) ? rx_base + addr_w'(rx_idx)
                                              : tx_base + tx_ptr;
    assign mem_we    = (state == st_rx_store) && !rx_fe;
    assign mem_wdata = rx_byte;

endmodule

`default_nettype wire

/* acia_rx.sv */
// acia 8N1 receiver
// 16x oversampled, start confirm at half bit, framing check on stop
`timescale 1ns/1ns
`default_nettype none

module acia_rx import acia_loop_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       tick,
    input  logic [6:0] bit_len,
    input  logic       rx,
    output logic [7:0] data,
    output logic       done,
    output logic       frame_err
);

    logic       rx_meta;
    logic       rx_sync;
    logic       rx_last;
    rx_state_e  state;
    logic [6:0] tick_cnt;
    logic [6:0] half_len;
    logic [6:0] wait_len;
    logic [2:0] bit_idx;
    logic [7:0] shift;
    logic       sample_pt;

    assign half_len = bit_len >> 1;
    // start is checked half a bit in, every later sample one bit apart
    assign wait_len  = (state == rx_start) ? half_len : bit_len;
    assign sample_pt = tick && (tick_cnt == wait_len - 7'd1);
    assign data      = shift;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;   // edge detect
        end
    end

    always_ff @(posedge clk) begin
        if (sample_pt && state == rx_data) begin
            shift <= {rx_sync, shift[7:1]};   // lsb arrives first
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state     <= rx_idle;
            tick_cnt  <= '0;
            bit_idx   <= '0;
            done      <= 1'b0;
            frame_err <= 1'b0;
        end else begin
            done <= 1'b0;
            if (state == rx_idle) begin
                if (rx_last && !rx_sync) begin
                    state    <= rx_start;
                    tick_cnt <= '0;
                end
            end else if (sample_pt) begin
                tick_cnt <= '0;
                case (state)
                    rx_start: begin
                        if (rx_sync) begin
                            state <= rx_idle;   // glitch, not a start bit
                        end else begin
                            state   <= rx_data;
                            bit_idx <= '0;
                        end
                    end
                    rx_data: begin
                        if (bit_idx == 3'd7) begin
                            state <= rx_stop;
                        end else begin
                            bit_idx <= bit_idx + 3'd1;
                        end
                    end
                    default: begin
                        state     <= rx_idle;
                        done      <= 1'b1;
                        frame_err <= !rx_sync;   // stop sampled low
                    end
                endcase
            end else if (tick) begin
                tick_cnt <= tick_cnt + 7'd1;
            end
        end
    end

endmodule

`default_nettype wire

/* acia_tx.sv */
// acia 8N1 transmitter
// holding register feeding a shift register, lsb first
`timescale 1ns/1ns
`default_nettype none

module acia_tx import acia_loop_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       tick,
    input  logic [6:0] bit_len,
    input  logic       load,
    input  logic [7:0] data,
    output logic       empty,
    output logic       tx
);

    tx_state_e  state;
    logic [7:0] hold;
    logic       hold_full;
    logic [7:0] shift;
    logic [6:0] tick_cnt;
    logic [2:0] bit_idx;
    logic       bit_end;
    logic       take;

    assign bit_end = tick && (tick_cnt == bit_len - 7'd1);
    // next byte moves over when the line is idle or a stop bit ends
    assign take = tick && hold_full &&
                  ((state == tx_idle) || ((state == tx_stop) && bit_end));
    assign empty = !hold_full;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hold_full <= 1'b0;
        end else if (load) begin
            hold_full <= 1'b1;
        end else if (take) begin
            hold_full <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            hold <= data;
        end
        if (take) begin
            shift <= hold;
        end else if (bit_end && (state == tx_start || state == tx_data)) begin
            shift <= shift >> 1;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= tx_idle;
            tick_cnt <= '0;
            bit_idx  <= '0;
            tx       <= 1'b1;     // line idles high
        end else if (take) begin
            state    <= tx_start;
            tick_cnt <= '0;
            tx       <= 1'b0;     // start bit
        end else if (tick && state != tx_idle) begin
            if (!bit_end) begin
                tick_cnt <= tick_cnt + 7'd1;
            end else begin
                tick_cnt <= '0;
                case (state)
                    tx_start: begin
                        state   <= tx_data;
                        bit_idx <= '0;
                        tx      <= shift[0];
                    end
                    tx_data: begin
                        if (bit_idx == 3'd7) begin
                            state <= tx_stop;
                            tx    <= 1'b1;
                        end else begin
                            bit_idx <= bit_idx + 3'd1;
                            tx      <= shift[0];
                        end
                    end
                    default: state <= tx_idle;   // stop bit done
                endcase
            end
        end
    end

endmodule

`default_nettype wire

/* run.sh */
#!/bin/sh
# compile and run the acia_loop testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module tb_acia_loop -Mdir obj_dir -f acia_loop.f
build_status=$?
if [ $build_status -ne 0 ]; then
    echo "verilator build failed with status $build_status"
    exit 1
fi

sim_out=$(./obj_dir/Vtb_acia_loop +verilator+error+limit+100)
sim_status=$?
printf '%s\n' "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -qx 'TEST PASSED'; then
    exit 0
fi
exit 1

/* tb_acia_loop.sv */
// acia_loop testbench
// drives rx frames, decodes the tx stream, checks stores into the receive region
`timescale 1ns/1ns
`default_nettype none

module tb_acia_loop
    import acia_loop_pkg::*;
();

    localparam int bit_cycles  = bit_ticks_16 * ovs_div;   // 32 clocks per bit
    localparam int rx_off      = 'h10;                     // rx entries in the vectors
    localparam int img_off     = 'h30;                     // expected region image
    localparam int start_limit = 2000;
    localparam int store_limit = 20000;

    logic              clk;
    logic              arst_n;
    logic              rx;
    logic              tx;
    logic [addr_w-1:0] mem_addr;
    logic [7:0]        mem_rdata;
    logic [7:0]        mem_wdata;
    logic              mem_we;

    logic [11:0] vec [0:63];
    logic [7:0]  mem [0:65535];
    logic [15:0] exp_addr_q[$];
    logic [7:0]  exp_data_q[$];
    int          errors;
    int          checks;
    integer      seed;
    logic        rx_sent;

    acia_loop_top i_dut (
        .clk       (clk),
        .arst_n    (arst_n),
        .rx        (rx),
        .tx        (tx),
        .mem_addr  (mem_addr),
        .mem_rdata (mem_rdata),
        .mem_wdata (mem_wdata),
        .mem_we    (mem_we)
    );

    bind acia_pump acia_loop_asserts i_asserts (
        .clk      (clk),
        .arst_n   (arst_n),
        .state    (state),
        .cs       (cs),
        .we       (we),
        .rs       (rs),
        .mem_we   (mem_we),
        .mem_addr (mem_addr)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // single-port memory, read data one cycle after the address
    initial begin
        int a;
        mem_rdata = 8'h00;
        $readmemh("acia_loop_vectors.txt", vec);
        for (a = 0; a < 65536; a++) begin
            mem[a] = 8'(a >> 8) ^ 8'(a) ^ 8'h5a;
        end
        a = 0;
        while (a < 16 && vec[a] != 12'h000) begin
            mem[tx_base + 16'(a)] = vec[a][7:0];
            a++;
        end
        mem[tx_base + 16'(a)] = 8'h00;   // string terminator
        forever begin
            @(posedge clk);
            mem_rdata <= mem[mem_addr];
            if (mem_we) begin
                mem[mem_addr] <= mem_wdata;
            end
        end
    end

    task automatic check_value(input string name, input logic [15:0] exp_val,
                               input logic [15:0] act_val);
        checks++;
        if (act_val !== exp_val) begin
            errors++;
            $display("mismatch %s exp %h act %h at %0t ns", name, exp_val, act_val, $time);
        end
    endtask

    task automatic build_expected_stores();
        int n;
        int good;
        n = 0;
        good = 0;
        while (n < 32 && vec[rx_off + n] != 12'hfff) begin
            if (!vec[rx_off + n][8]) begin   // bad stop leaves the index alone
                exp_addr_q.push_back(rx_base + 16'(good % rx_len));
                exp_data_q.push_back(vec[rx_off + n][7:0]);
                good++;
            end
            n++;
        end
    endtask

    task automatic drive_bit(input logic level);
        @(posedge clk);
        rx <= level;
        repeat (bit_cycles - 1) @(posedge clk);
    endtask

    task automatic drive_frame(input logic [7:0] value, input logic bad_stop);
        int k;
        drive_bit(1'b0);
        for (k = 0; k < 8; k++) begin
            drive_bit(value[k]);   // lsb first
        end
        drive_bit(!bad_stop);
    endtask

    task automatic drive_rx_frames();
        int n;
        int gap;
        n = 0;
        repeat (20) @(posedge clk);
        while (n < 32 && vec[rx_off + n] != 12'hfff) begin
            drive_frame(vec[rx_off + n][7:0], vec[rx_off + n][8]);
            gap = 6 + int'($unsigned($random(seed)) % 32);
            @(posedge clk);
            rx <= 1'b1;
            repeat (gap) @(posedge clk);
            n++;
        end
        rx_sent = 1'b1;
    endtask

    task automatic wait_tx_start(output logic found);
        int cnt;
        found = 1'b0;
        cnt = 0;
        while (!found && cnt < start_limit) begin
            @(negedge clk);
            found = !tx;
            cnt++;
        end
    endtask

    task automatic read_tx_frame(output logic [7:0] value);
        int k;
        repeat (bit_cycles / 2 - 1) @(negedge clk);   // middle of the start bit
        check_value("tx_start", 16'h0, 16'(tx));
        for (k = 0; k < 8; k++) begin
            repeat (bit_cycles) @(negedge clk);
            value[k] = tx;
        end
        repeat (bit_cycles) @(negedge clk);
        check_value("tx_stop", 16'h1, 16'(tx));
    endtask

    task automatic watch_tx_frames();
        int n;
        int cnt;
        logic found;
        logic [7:0] value;
        n = 0;
        found = 1'b1;
        while (found && n < 16 && vec[n] != 12'h000) begin
            wait_tx_start(found);
            if (!found) begin
                $display("no start bit on tx for byte %0d within %0d cycles", n, start_limit);
                errors++;
            end else begin
                read_tx_frame(value);
                check_value("tx_byte", 16'(vec[n][7:0]), 16'(value));
            end
            n++;
        end
        cnt = 0;
        while (found && cnt < 2 * 10 * bit_cycles) begin   // line stays quiet
            @(negedge clk);
            if (!tx) begin
                $display("tx sends a start bit after the terminator");
                errors++;
                found = 1'b0;
            end
            cnt++;
        end
    endtask

    task automatic watch_stores();
        int cnt;
        cnt = 0;
        while (!(rx_sent && exp_addr_q.size() == 0) && cnt < store_limit) begin
            @(negedge clk);
            if (mem_we) begin
                if (exp_addr_q.size() == 0) begin
                    $display("unexpected memory write at address %h", mem_addr);
                    errors++;
                end else begin
                    check_value("mem_addr", exp_addr_q.pop_front(), mem_addr);
                    check_value("mem_wdata", 16'(exp_data_q.pop_front()), 16'(mem_wdata));
                end
            end
            cnt++;
        end
        if (exp_addr_q.size() != 0) begin
            $display("%0d receive stores did not happen in time", exp_addr_q.size());
            errors++;
        end
    endtask

    task automatic check_rx_image();
        int i;
        for (i = 0; i < rx_len; i++) begin
            check_value($sformatf("mem[%h]", rx_base + 16'(i)),
                        16'(vec[img_off + i][7:0]), 16'(mem[rx_base + 16'(i)]));
        end
    endtask

    initial begin
        int n;
        errors  = 0;
        checks  = 0;
        seed    = 32'h7c442f4e;
        rx_sent = 1'b0;
        arst_n  = 1'b0;
        rx      = 1'b1;
        for (n = 0; n < 8; n++) begin
            @(negedge clk);
            check_value("tx", 16'h1, 16'(tx));
            check_value("mem_we", 16'h0, 16'(mem_we));
        end
        build_expected_stores();
        @(posedge clk);
        arst_n <= 1'b1;
        for (n = 0; n < 4; n++) begin   // configuration, no frame yet
            @(negedge clk);
            check_value("tx", 16'h1, 16'(tx));
            check_value("mem_we", 16'h0, 16'(mem_we));
        end
        fork
            drive_rx_frames();
            watch_tx_frames();
            watch_stores();
        join
        check_rx_image();
        errors += i_dut.i_pump.i_asserts.fail_count;
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
